// ==== hw/qa_defines.svh ====
// QA shared constants for line width, status area size, register map and identifier words
`ifndef QA_DEFINES_SVH
`define QA_DEFINES_SVH

// One host cache line, in bits
`define QA_LINE_BITS 128

// Lines in the host status area that the tests touch
`define QA_DSM_LINES 16

// Accelerator identifier, word 0 is the lowest word of the line
`define QA_AFU_ID_W0 32'haced0000
`define QA_AFU_ID_W1 32'haced0001
`define QA_AFU_ID_W2 32'haced0002
`define QA_AFU_ID_W3 32'haced0003

// Host register addresses on the 4-bit CSR port
`define QA_CSR_ADDR_DSM_BASE  4'h0
`define QA_CSR_ADDR_ENABLE    4'h1
`define QA_CSR_ADDR_DEBUG     4'h2
`define QA_CSR_ADDR_NUM_LINES 4'h3

`endif

// ==== hw/qa_pkg.sv ====
// QA package with the CSR state, write channel and status line types
`include "qa_defines.svh"

package qa_pkg;

    // ==============================
    // Control state
    // ==============================

    // Held register values plus the one-cycle command pulses
    typedef struct packed {
        logic [31:0] dsm_base;
        logic        dsm_base_valid;
        logic        enable_test;
        // Zero means no debug trigger this cycle
        logic [7:0]  trigger_debug;
        logic [3:0]  num_lines;
    } csr_state_t;

    // ==============================
    // Write channel
    // ==============================

    // A peer holds request high until it sees its grant bit
    typedef struct packed {
        logic                      request;
        logic [31:0]               address;
        logic [`QA_LINE_BITS-1:0]  data;
    } wr_req_t;

    typedef struct packed {
        logic status_grant;
        logic tester_grant;
    } wr_grant_t;

    // Outgoing host channel, valid is high for one cycle per write
    typedef struct packed {
        logic                      valid;
        logic [31:0]               address;
        logic [`QA_LINE_BITS-1:0]  data;
    } host_wr_t;

    // ==============================
    // Status line
    // ==============================

    typedef logic [31:0] debug_rsp_t;

    // Debug dump layout, the response sits in the lowest word
    typedef struct packed {
        logic [`QA_LINE_BITS-41:0] pad;
        logic [7:0]                req;
        debug_rsp_t                rsp;
    } debug_line_t;

    // Line 0 carries either the identifier or a debug dump
    typedef union packed {
        logic [3:0][31:0] id;
        debug_line_t      dbg;
    } status_line_u;

endpackage

// ==== hw/qa_csr.sv ====
// QA CSR block that turns host register writes into held state and command pulses
`include "qa_defines.svh"

module qa_csr
    (
        input  logic                clk,
        input  logic                resetb,
        input  logic                csr_wr,
        input  logic [3:0]          csr_addr,
        input  logic [31:0]         csr_data,
        output qa_pkg::csr_state_t  csr,
        output qa_pkg::debug_rsp_t  dbg_csr
    );

    logic [31:0] dsm_base;
    logic        dsm_base_valid;
    logic        enable_test;
    logic [7:0]  trigger_debug;
    logic [3:0]  num_lines;
    logic [31:0] wr_count;

    // The base address is plain payload and only changes on its own write
    always_ff @(posedge clk)
    begin
        if (csr_wr && (csr_addr == `QA_CSR_ADDR_DSM_BASE))
        begin
            dsm_base <= csr_data;
        end
    end

    // Held bits, pulses and the write counter
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dsm_base_valid <= 1'b0;
            enable_test    <= 1'b0;
            trigger_debug  <= 8'd0;
            num_lines      <= 4'd0;
            wr_count       <= 32'd0;
        end
        else
        begin
            // Pulses fall back to zero unless this cycle sets them again
            enable_test   <= csr_wr && (csr_addr == `QA_CSR_ADDR_ENABLE);
            trigger_debug <= 8'd0;
            if (csr_wr)
            begin
                wr_count <= wr_count + 32'd1;
                case (csr_addr)
                    `QA_CSR_ADDR_DSM_BASE:  dsm_base_valid <= 1'b1;
                    `QA_CSR_ADDR_DEBUG:     trigger_debug  <= csr_data[7:0];
                    `QA_CSR_ADDR_NUM_LINES: num_lines      <= csr_data[3:0];
                    default:                ;
                endcase
            end
        end
    end

    assign csr = '{dsm_base:       dsm_base,
                   dsm_base_valid: dsm_base_valid,
                   enable_test:    enable_test,
                   trigger_debug:  trigger_debug,
                   num_lines:      num_lines};

    assign dbg_csr = wr_count;

endmodule

// ==== hw/qa_status_writer.sv ====
// QA status writer that posts the identifier or a debug dump to status line 0
`include "qa_defines.svh"

module qa_status_writer
    (
        input  logic                clk,
        input  logic                resetb,
        input  qa_pkg::csr_state_t  csr,
        input  qa_pkg::wr_grant_t   write_grant,
        input  qa_pkg::debug_rsp_t  dbg_csr,
        input  qa_pkg::debug_rsp_t  dbg_tester,
        input  qa_pkg::debug_rsp_t  dbg_arb,
        output qa_pkg::wr_req_t     status_writer
    );

    typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_DEBUG} state_t;

    state_t               state;
    state_t               next_state;
    logic [7:0]           dbg_req;
    qa_pkg::debug_rsp_t   dbg_rsp;
    qa_pkg::debug_rsp_t   dbg_sel;
    qa_pkg::status_line_u line;

    // ==============================
    // FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= ST_INIT;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Only one write is in flight; a grant always finishes it first
    always_comb
    begin
        next_state = state;
        if (write_grant.status_grant)
        begin
            next_state = ST_IDLE;
        end
        else if (csr.enable_test)
        begin
            // A new test announces itself by rewriting the identifier
            next_state = ST_INIT;
        end
        else if (csr.trigger_debug != 8'd0)
        begin
            next_state = ST_DEBUG;
        end
    end

    // ==============================
    // Debug capture
    // ==============================

    // Index 1 and any unknown index report the CSR write count
    always_comb
    begin
        case (csr.trigger_debug)
            8'd2:    dbg_sel = dbg_tester;
            8'd3:    dbg_sel = dbg_arb;
            default: dbg_sel = dbg_csr;
        endcase
    end

    // The word is frozen at trigger time so later traffic does not move it
    always_ff @(posedge clk)
    begin
        if (csr.trigger_debug != 8'd0)
        begin
            dbg_req <= csr.trigger_debug;
            dbg_rsp <= dbg_sel;
        end
    end

    // Build line 0 through whichever view matches the state
    always_comb
    begin
        line = '0;
        if (state == ST_DEBUG)
        begin
            line.dbg.req = dbg_req;
            line.dbg.rsp = dbg_rsp;
        end
        else
        begin
            line.id[0] = `QA_AFU_ID_W0;
            line.id[1] = `QA_AFU_ID_W1;
            line.id[2] = `QA_AFU_ID_W2;
            line.id[3] = `QA_AFU_ID_W3;
        end
    end

    // Nothing goes out until the host has given a base address
    assign status_writer.request = (state != ST_IDLE) && csr.dsm_base_valid;
    assign status_writer.address = csr.dsm_base;
    assign status_writer.data    = line;

endmodule

// ==== hw/qa_line_tester.sv ====
// QA line tester that writes a counted run of patterned lines after status line 0
`include "qa_defines.svh"

module qa_line_tester
    (
        input  logic                clk,
        input  logic                resetb,
        input  qa_pkg::csr_state_t  csr,
        input  qa_pkg::wr_grant_t   write_grant,
        output qa_pkg::wr_req_t     tester_writer,
        output qa_pkg::debug_rsp_t  dbg_tester
    );

    logic [3:0]  run_idx;
    logic [3:0]  remaining;
    logic [31:0] lines_written;
    logic [31:0] pattern;

    // Run position and remaining count
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            run_idx   <= 4'd0;
            remaining <= 4'd0;
        end
        else if (csr.enable_test)
        begin
            // A fresh enable restarts the run even if one is still going
            run_idx   <= 4'd0;
            remaining <= csr.num_lines;
        end
        else if (write_grant.tester_grant)
        begin
            run_idx   <= run_idx + 4'd1;
            remaining <= remaining - 4'd1;
        end
    end

    // Lifetime count, a grant that meets an enable still counts as written
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            lines_written <= 32'd0;
        end
        else if (write_grant.tester_grant)
        begin
            lines_written <= lines_written + 32'd1;
        end
    end

    assign pattern = 32'h5a00_0000 + {28'd0, run_idx};

    // Line k of the run lands right after status line 0
    assign tester_writer.request = (remaining != 4'd0);
    assign tester_writer.address = csr.dsm_base + 32'd1 + {28'd0, run_idx};
    assign tester_writer.data    = {(`QA_LINE_BITS / 32){pattern}};

    assign dbg_tester = lines_written;

endmodule

// ==== hw/qa_write_arb.sv ====
// QA write arbiter that shares the host write channel between the two peers round robin
`include "qa_defines.svh"

module qa_write_arb
    (
        input  logic                clk,
        input  logic                resetb,
        input  qa_pkg::wr_req_t     status_writer,
        input  qa_pkg::wr_req_t     tester_writer,
        input  logic                almost_full,
        output qa_pkg::wr_grant_t   write_grant,
        output qa_pkg::host_wr_t    host_wr,
        output qa_pkg::debug_rsp_t  dbg_arb
    );

    logic                     last_was_tester;
    logic                     hw_valid;
    logic [31:0]              hw_address;
    logic [`QA_LINE_BITS-1:0] hw_data;
    logic [31:0]              grant_count;

    // Grants are combinational; a tie goes to whoever lost last time
    always_comb
    begin
        write_grant = '0;
        if (!almost_full)
        begin
            if (status_writer.request && tester_writer.request)
            begin
                write_grant.status_grant = last_was_tester;
                write_grant.tester_grant = !last_was_tester;
            end
            else
            begin
                write_grant.status_grant = status_writer.request;
                write_grant.tester_grant = tester_writer.request;
            end
        end
    end

    // ==============================
    // Channel register
    // ==============================

    // Reset leaves the status writer ahead on the first tie
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            last_was_tester <= 1'b1;
            hw_valid        <= 1'b0;
            grant_count     <= 32'd0;
        end
        else
        begin
            hw_valid <= write_grant.status_grant || write_grant.tester_grant;
            if (write_grant.status_grant || write_grant.tester_grant)
            begin
                last_was_tester <= write_grant.tester_grant;
                grant_count     <= grant_count + 32'd1;
            end
        end
    end

    // Address and data of the winner, one cycle behind the grant
    always_ff @(posedge clk)
    begin
        if (write_grant.status_grant)
        begin
            hw_address <= status_writer.address;
            hw_data    <= status_writer.data;
        end
        else if (write_grant.tester_grant)
        begin
            hw_address <= tester_writer.address;
            hw_data    <= tester_writer.data;
        end
    end

    assign host_wr = '{valid:   hw_valid,
                       address: hw_address,
                       data:    hw_data};
    assign dbg_arb = grant_count;

endmodule

// ==== hw/qa_top.sv ====
// QA top level joining the CSR block, the status writer, the line tester and the arbiter
module qa_top
    (
        input  logic              clk,
        input  logic              resetb,
        input  logic              csr_wr,
        input  logic [3:0]        csr_addr,
        input  logic [31:0]       csr_data,
        input  logic              almost_full,
        output qa_pkg::host_wr_t  host_wr
    );

    qa_pkg::csr_state_t  csr;
    qa_pkg::wr_req_t     status_writer;
    qa_pkg::wr_req_t     tester_writer;
    qa_pkg::wr_grant_t   write_grant;
    qa_pkg::debug_rsp_t  dbg_csr;
    qa_pkg::debug_rsp_t  dbg_tester;
    qa_pkg::debug_rsp_t  dbg_arb;

    // Host register decode
    qa_csr qa_csr_i
        (.clk(clk), .resetb(resetb), .csr_wr(csr_wr), .csr_addr(csr_addr),
         .csr_data(csr_data), .csr(csr), .dbg_csr(dbg_csr));

    // The two peers sharing the write channel
    qa_status_writer qa_status_writer_i
        (.clk(clk), .resetb(resetb), .csr(csr), .write_grant(write_grant),
         .dbg_csr(dbg_csr), .dbg_tester(dbg_tester), .dbg_arb(dbg_arb),
         .status_writer(status_writer));

    qa_line_tester qa_line_tester_i
        (.clk(clk), .resetb(resetb), .csr(csr), .write_grant(write_grant),
         .tester_writer(tester_writer), .dbg_tester(dbg_tester));

    qa_write_arb qa_write_arb_i
        (.clk(clk), .resetb(resetb), .status_writer(status_writer),
         .tester_writer(tester_writer), .almost_full(almost_full),
         .write_grant(write_grant), .host_wr(host_wr), .dbg_arb(dbg_arb));

endmodule

// ==== verif/qa_properties.sv ====
// QA arbiter assertions on grant exclusivity, back-pressure and the channel valid pulse
module qa_properties
    (
        input logic               clk,
        input logic               resetb,
        input qa_pkg::wr_req_t    status_writer,
        input qa_pkg::wr_req_t    tester_writer,
        input logic               almost_full,
        input qa_pkg::wr_grant_t  write_grant,
        input qa_pkg::host_wr_t   host_wr
    );

    timeunit 1ns;
    timeprecision 1ps;

    logic any_grant;
    // Number of assertion failures so far
    int   assert_errors = 0;

    assign any_grant = write_grant.status_grant || write_grant.tester_grant;

    // Only one peer owns the channel in a cycle
    one_grant: assert property (@(posedge clk) disable iff (!resetb)
        !(write_grant.status_grant && write_grant.tester_grant))
    else
    begin
        $error("Both peers were granted in the same cycle");
        assert_errors++;
    end

    // Back-pressure blocks every grant
    no_grant_when_full: assert property (@(posedge clk) disable iff (!resetb)
        almost_full |-> !any_grant)
    else
    begin
        $error("A grant was given while almost_full was high");
        assert_errors++;
    end

    // Each grant shows up on the channel one cycle later
    grant_then_valid: assert property (@(posedge clk) disable iff (!resetb)
        any_grant |=> host_wr.valid)
    else
    begin
        $error("A grant was not followed by a channel write");
        assert_errors++;
    end

    status_requested: assert property (@(posedge clk) disable iff (!resetb)
        write_grant.status_grant |-> status_writer.request)
    else
    begin
        $error("The status writer was granted without a request");
        assert_errors++;
    end

    tester_requested: assert property (@(posedge clk) disable iff (!resetb)
        write_grant.tester_grant |-> tester_writer.request)
    else
    begin
        $error("The line tester was granted without a request");
        assert_errors++;
    end

endmodule

bind qa_write_arb qa_properties qa_properties_i
    (.clk(clk), .resetb(resetb), .status_writer(status_writer),
     .tester_writer(tester_writer), .almost_full(almost_full),
     .write_grant(write_grant), .host_wr(host_wr));

// ==== verif/qa_checker.sv ====
// QA checker that rebuilds the expected host writes from the DUT ports and compares them
`include "qa_defines.svh"

module qa_checker
    (
        input  logic              clk,
        input  logic              resetb,
        input  logic              csr_wr,
        input  logic [3:0]        csr_addr,
        input  logic [31:0]       csr_data,
        input  logic              almost_full,
        input  qa_pkg::host_wr_t  host_wr,
        output logic              quiet,
        output int                value_errors,
        output int                other_errors,
        output int                write_count
    );

    timeunit 1ns;
    timeprecision 1ps;

    // Register state as the host programmed it
    logic [31:0]              base;
    logic                     base_valid;
    logic [3:0]               num_lines;
    int                       csr_count;

    // Writes the DUT still owes
    logic                     status_want;
    logic [`QA_LINE_BITS-1:0] status_expect;
    int                       tester_left;
    int                       tester_k;
    int                       tester_count;

    // Debug trigger waiting for its capture cycle
    logic                     capture_next;
    logic [7:0]               dbg_idx;
    int                       csr_snap;

    logic                     af_last;
    logic [`QA_LINE_BITS-1:0] image [`QA_DSM_LINES];

    // Identifier line with word 0 in the lowest bits
    function automatic logic [`QA_LINE_BITS-1:0] id_line();
        id_line = {`QA_AFU_ID_W3, `QA_AFU_ID_W2, `QA_AFU_ID_W1, `QA_AFU_ID_W0};
    endfunction

    // Line k of a test run repeats one 32-bit word across the line
    function automatic logic [`QA_LINE_BITS-1:0] pattern_line(input int k);
        logic [31:0] word;
        word = 32'h5a00_0000 + 32'(k);
        pattern_line = {(`QA_LINE_BITS / 32){word}};
    endfunction

    // Record the expected line in the image and compare what arrived
    task automatic check_line(input int line, input logic [`QA_LINE_BITS-1:0] got,
                              input logic [`QA_LINE_BITS-1:0] want);
        image[line] = want;
        if (got !== image[line])
        begin
            $display("Fail host_wr.data line %0d: got %h, expected %h", line, got, want);
            value_errors++;
        end
    endtask

    // Nothing is owed once both peers are done and no trigger is waiting
    assign quiet = !(status_want && base_valid) && (tester_left == 0) && !capture_next;

    // ==============================
    // Model and compare
    // ==============================

    always @(posedge clk)
    begin
        logic [31:0] offset;
        logic [31:0] word;
        int          i;
        if (!resetb)
        begin
            base_valid    = 1'b0;
            num_lines     = 4'd0;
            csr_count     = 0;
            // After reset the status writer already owes the identifier
            status_want   = 1'b1;
            status_expect = id_line();
            tester_left   = 0;
            tester_k      = 0;
            tester_count  = 0;
            capture_next  = 1'b0;
            af_last       = 1'b0;
            write_count   = 0;
            for (i = 0; i < `QA_DSM_LINES; i++)
            begin
                image[i] = '0;
            end
        end
        else
        begin
            // Channel first, so a capture in this cycle already counts this write
            if (host_wr.valid)
            begin
                write_count++;
                offset = host_wr.address - base;
                if (af_last)
                begin
                    $display("A write arrived although almost_full was high the cycle before");
                    other_errors++;
                end
                if ((offset == 32'd0) && status_want && base_valid)
                begin
                    check_line(0, host_wr.data, status_expect);
                    status_want = 1'b0;
                end
                else if ((tester_left > 0) && (offset == 32'(tester_k + 1)))
                begin
                    check_line(tester_k + 1, host_wr.data, pattern_line(tester_k));
                    tester_k++;
                    tester_left--;
                    tester_count++;
                end
                else
                begin
                    $display("Unexpected write to address %h, no such line was pending",
                             host_wr.address);
                    other_errors++;
                end
            end
            // The debug word is frozen one cycle after its trigger strobe
            if (capture_next)
            begin
                case (dbg_idx)
                    8'd2:    word = 32'(tester_count);
                    8'd3:    word = 32'(write_count);
                    default: word = 32'(csr_snap);
                endcase
                status_expect = {{(`QA_LINE_BITS - 40){1'b0}}, dbg_idx, word};
                status_want   = 1'b1;
                capture_next  = 1'b0;
            end
            if (csr_wr)
            begin
                csr_count++;
                case (csr_addr)
                    `QA_CSR_ADDR_DSM_BASE:
                    begin
                        base       = csr_data;
                        base_valid = 1'b1;
                    end
                    `QA_CSR_ADDR_ENABLE:
                    begin
                        status_want   = 1'b1;
                        status_expect = id_line();
                        tester_left   = int'(num_lines);
                        tester_k      = 0;
                    end
                    `QA_CSR_ADDR_DEBUG:
                    begin
                        if (csr_data[7:0] != 8'd0)
                        begin
                            dbg_idx      = csr_data[7:0];
                            csr_snap     = csr_count;
                            capture_next = 1'b1;
                        end
                    end
                    `QA_CSR_ADDR_NUM_LINES: num_lines = csr_data[3:0];
                    default:                ;
                endcase
            end
            af_last = almost_full;
        end
    end

endmodule

// ==== verif/qa_tb.sv ====
// QA testbench top running seeded random register episodes under random back-pressure
`include "qa_defines.svh"

module qa_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             resetb;
    logic             csr_wr;
    logic [3:0]       csr_addr;
    logic [31:0]      csr_data;
    logic             almost_full;
    qa_pkg::host_wr_t host_wr;
    logic             quiet;
    int               value_errors;
    int               other_errors;
    int               write_count;
    int               timeouts;
    // Cycles left in a forced almost_full burst
    int               af_hold;

    qa_top qa_top_i
        (.clk(clk), .resetb(resetb), .csr_wr(csr_wr), .csr_addr(csr_addr),
         .csr_data(csr_data), .almost_full(almost_full), .host_wr(host_wr));

    qa_checker qa_checker_i
        (.clk(clk), .resetb(resetb), .csr_wr(csr_wr), .csr_addr(csr_addr),
         .csr_data(csr_data), .almost_full(almost_full), .host_wr(host_wr),
         .quiet(quiet), .value_errors(value_errors), .other_errors(other_errors),
         .write_count(write_count));

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // One clock edge, with almost_full redrawn or held for a burst
    task automatic step();
        @(posedge clk);
        if (af_hold > 0)
        begin
            almost_full <= 1'b1;
            af_hold--;
        end
        else
        begin
            almost_full <= (($urandom % 100) < 35);
        end
    endtask

    // Single-cycle register write strobe
    task automatic csr_write(input logic [3:0] addr, input logic [31:0] data);
        step();
        csr_wr   <= 1'b1;
        csr_addr <= addr;
        csr_data <= data;
        step();
        csr_wr   <= 1'b0;
    endtask

    // Poll the checker between edges until it owes no write
    task automatic wait_quiet(input string what, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 600; n++)
        begin
            @(negedge clk);
            if (quiet)
            begin
                ok = 1'b1;
                break;
            end
            step();
        end
        if (!ok)
        begin
            $display("Timed out waiting for the DUT to finish %s", what);
            timeouts++;
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        int ep;
        bit ok;
        int assert_count;
        void'($urandom(51));
        resetb      = 1'b0;
        csr_wr      = 1'b0;
        csr_addr    = 4'd0;
        csr_data    = 32'd0;
        almost_full = 1'b0;
        af_hold     = 0;
        timeouts    = 0;
        repeat (4) @(posedge clk);
        resetb <= 1'b1;
        for (ep = 0; ep < 24; ep++)
        begin
            csr_write(`QA_CSR_ADDR_DSM_BASE, $urandom);
            if (ep == 0)
            begin
                // The first base write releases the identifier owed since reset
                wait_quiet("the first identifier write", ok);
                if (!ok)
                begin
                    break;
                end
            end
            // Roughly one episode in four starts inside a long back-pressure burst
            if (($urandom % 4) == 0)
            begin
                af_hold = 10 + int'($urandom % 20);
            end
            csr_write(`QA_CSR_ADDR_NUM_LINES, $urandom % 15);
            csr_write(`QA_CSR_ADDR_ENABLE, 32'd1);
            wait_quiet("a test run", ok);
            if (!ok)
            begin
                break;
            end
            csr_write(`QA_CSR_ADDR_DEBUG, 32'd1 + ($urandom % 4));
            wait_quiet("a debug dump", ok);
            if (!ok)
            begin
                break;
            end
        end
        // Give any stray late write time to show up at the checker
        for (ep = 0; ep < 20; ep++)
        begin
            step();
        end
        assert_count = qa_top_i.qa_write_arb_i.qa_properties_i.assert_errors;
        $display("Errors: value %0d, other %0d, timeout %0d, assertion %0d (writes seen %0d)",
                 value_errors, other_errors, timeouts, assert_count, write_count);
        if ((value_errors + other_errors + timeouts + assert_count) == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
hw/qa_pkg.sv
hw/qa_csr.sv
hw/qa_status_writer.sv
hw/qa_line_tester.sv
hw/qa_write_arb.sv
hw/qa_top.sv
verif/qa_properties.sv
verif/qa_checker.sv
verif/qa_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the QA testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f compile.f --top-module qa_tb -Mdir obj_dir -o qa_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/qa_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
